/* hdl/pe_array_consts.svh */
// Grid, tile, bit-plane and width constants for the PE array
// Shared by the packages, the interface and all RTL modules

`ifndef PE_ARRAY_CONSTS_SVH
`define PE_ARRAY_CONSTS_SVH

// PEs per row and per column
`define GRID_DIM 4
// Tile side, rows and columns
`define TILE_DIM 4
// Weight bit planes, plane p weighs 2**p
`define NUM_PLANES 4
`define ACT_W 8
`define RESULT_W 32
// Row or column select width
`define SEL_W 2

`endif

/* hdl/pe_data_pkg.sv */
// Payload types of the PE array
// Activations, weight bit planes, tiles and results

`default_nettype none

`include "pe_array_consts.svh"

package pe_data_pkg;

    // One signed activation
    typedef logic signed [`ACT_W-1:0] act_t;

    // Activation tile, indexed [row i][inner k]
    typedef act_t [`TILE_DIM-1:0][`TILE_DIM-1:0] act_tile_t;

    // One weight bit plane, indexed [inner k][col j]
    typedef logic [`TILE_DIM-1:0][`TILE_DIM-1:0] plane_tile_t;

    // All planes of one weight tile, lowest plane at index 0
    typedef plane_tile_t [`NUM_PLANES-1:0] weight_tile_t;

    typedef logic signed [`RESULT_W-1:0] result_t;

    // Result tile, indexed [row i][col j]
    typedef result_t [`TILE_DIM-1:0][`TILE_DIM-1:0] result_tile_t;

endpackage

`default_nettype wire

/* hdl/pe_ctrl_pkg.sv */
// Control enumerations of the PE array
// PE FSM states and tile load kinds

`default_nettype none

package pe_ctrl_pkg;

    // PE FSM states
    typedef enum logic [1:0] {
        state_idle = 2'd0,
        state_busy = 2'd1,
        state_done = 2'd2
    } pe_state_t;

    // Kind of tile load, one-cycle strobe
    typedef enum logic [1:0] {
        load_none = 2'd0,
        load_line = 2'd1,
        load_all  = 2'd2
    } load_kind_t;

endpackage

`default_nettype wire

/* hdl/tile_load_if.sv */
// Load command and payload bundle from the broadcast decoder to the tile stores

`timescale 1ns/1ps
`default_nettype none

`include "pe_array_consts.svh"

interface tile_load_if
    import pe_data_pkg::*;
    import pe_ctrl_pkg::*;
();

    // Weight half, addressed by row
    load_kind_t                        weight_kind;
    logic [`SEL_W-1:0]                 weight_line;
    weight_tile_t [`GRID_DIM-1:0]      weight_src;

    // Activation half, addressed by column
    load_kind_t                        act_kind;
    logic [`SEL_W-1:0]                 act_line;
    act_tile_t [`GRID_DIM-1:0]         act_src;

    modport source (
        output weight_kind, weight_line, weight_src,
        output act_kind, act_line, act_src
    );

    modport sink (
        input weight_kind, weight_line, weight_src,
        input act_kind, act_line, act_src
    );

endinterface

`default_nettype wire

/* hdl/broadcast_decoder.sv */
// Broadcast decoder
// Turns top-level broadcast strobes and buffers into row and column load commands

`timescale 1ns/1ps
`default_nettype none

`include "pe_array_consts.svh"

module broadcast_decoder
    import pe_data_pkg::*;
    import pe_ctrl_pkg::*;
(
    input  logic                                         broadcast_enable,
    input  logic                                         broadcast_weights,
    input  logic                                         broadcast_activations,
    input  logic                                         broadcast_all,
    input  logic [`SEL_W-1:0]                            broadcast_row_select,
    input  logic [`SEL_W-1:0]                            broadcast_col_select,
    input  logic [`GRID_DIM*$bits(weight_tile_t)-1:0]    row_weight_buffer,
    input  logic [`GRID_DIM*$bits(act_tile_t)-1:0]      col_activation_buffer,
    tile_load_if.source                                  ld
);

    localparam int weight_bits = $bits(weight_tile_t);
    localparam int act_bits    = $bits(act_tile_t);

    // ====================
    // Load kind decode
    // ====================

    always_comb begin
        ld.weight_kind = load_none;
        ld.act_kind    = load_none;
        if (broadcast_enable) begin
            // Load-all overrides the per-line strobes
            if (broadcast_all) begin
                ld.weight_kind = load_all;
                ld.act_kind    = load_all;
            end else begin
                if (broadcast_weights) begin
                    ld.weight_kind = load_line;
                end
                if (broadcast_activations) begin
                    ld.act_kind = load_line;
                end
            end
        end
    end

    assign ld.weight_line = broadcast_row_select;
    assign ld.act_line    = broadcast_col_select;

    // ====================
    // Buffer unpacking
    // ====================

    // Entry r of the weight buffer belongs to row r, entry c of the
    // activation buffer to column c
    always_comb begin
        for (int r = 0; r < `GRID_DIM; r++) begin
            ld.weight_src[r] = row_weight_buffer[r*weight_bits +: weight_bits];
        end
        for (int c = 0; c < `GRID_DIM; c++) begin
            ld.act_src[c] = col_activation_buffer[c*act_bits +: act_bits];
        end
    end

endmodule

`default_nettype wire

/* hdl/tile_store.sv */
// Tile store
// One tile register per PE, loaded line-wise or all at once

`timescale 1ns/1ps
`default_nettype none

`include "pe_array_consts.svh"

module tile_store
    import pe_data_pkg::*;
    import pe_ctrl_pkg::*;
#(
    parameter type tile_t = weight_tile_t,
    // 1 takes the weight half by row, 0 the activation half by column
    parameter bit  by_row = 1'b1
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    tile_load_if.sink                                 ld,
    output tile_t [`GRID_DIM-1:0][`GRID_DIM-1:0]      tiles
);

    load_kind_t                  kind;
    logic [`SEL_W-1:0]           line;
    tile_t [`GRID_DIM-1:0]       src;

    // Pick the half of the load bundle that carries this payload
    if (by_row) begin : g_weight_half
        assign kind = ld.weight_kind;
        assign line = ld.weight_line;
        assign src  = ld.weight_src;
    end else begin : g_act_half
        assign kind = ld.act_kind;
        assign line = ld.act_line;
        assign src  = ld.act_src;
    end

    // ====================
    // Tile registers
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tiles <= '0;
        end else begin
            for (int r = 0; r < `GRID_DIM; r++) begin
                for (int c = 0; c < `GRID_DIM; c++) begin
                    // A PE belongs to line r for weights and line c for activations
                    if (kind == load_all ||
                        (kind == load_line && int'(line) == (by_row ? r : c))) begin
                        tiles[r][c] <= src[by_row ? r : c];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/processing_element.sv */
// Processing element
// Bit-plane serial 4x4 tile multiplier with activation threshold

`timescale 1ns/1ps
`default_nettype none

`include "pe_array_consts.svh"

module processing_element
    import pe_data_pkg::*;
    import pe_ctrl_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  act_t            threshold,
    input  weight_tile_t    weights,
    input  act_tile_t       acts,
    output logic            done,
    output result_tile_t    result
);

    localparam int plane_idx_w = $clog2(`NUM_PLANES);

    pe_state_t                  state;
    logic [plane_idx_w-1:0]     plane;
    result_tile_t               acc;
    act_tile_t                  act_q;
    result_tile_t               plane_sum;

    // ====================
    // Datapath
    // ====================

    // Activations below the threshold count as zero
    always_comb begin
        for (int i = 0; i < `TILE_DIM; i++) begin
            for (int k = 0; k < `TILE_DIM; k++) begin
                if ($signed(acts[i][k]) >= $signed(threshold)) begin
                    act_q[i][k] = acts[i][k];
                end else begin
                    act_q[i][k] = '0;
                end
            end
        end
    end

    // Contribution of the current plane, act * w_plane scaled by 2**plane
    always_comb begin
        plane_tile_t wplane;
        result_t     term;
        wplane = weights[plane];
        for (int i = 0; i < `TILE_DIM; i++) begin
            for (int j = 0; j < `TILE_DIM; j++) begin
                plane_sum[i][j] = '0;
                for (int k = 0; k < `TILE_DIM; k++) begin
                    // Sign-extend before the shift
                    term = result_t'($signed(act_q[i][k]));
                    if (wplane[k][j]) begin
                        plane_sum[i][j] = plane_sum[i][j] + (term <<< plane);
                    end
                end
            end
        end
    end

    // ====================
    // Control FSM
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= state_idle;
            plane <= '0;
            acc   <= '0;
        end else begin
            case (state)
                state_busy: begin
                    // One plane per cycle, lowest first
                    for (int i = 0; i < `TILE_DIM; i++) begin
                        for (int j = 0; j < `TILE_DIM; j++) begin
                            acc[i][j] <= acc[i][j] + plane_sum[i][j];
                        end
                    end
                    plane <= plane + 1'b1;
                    if (plane == plane_idx_w'(`NUM_PLANES - 1)) begin
                        state <= state_done;
                    end
                end
                default: begin
                    // Idle or done, a start clears and restarts
                    if (start) begin
                        acc   <= '0;
                        plane <= '0;
                        state <= state_busy;
                    end
                end
            endcase
        end
    end

    assign done   = (state == state_done);
    assign result = acc;

endmodule

`default_nettype wire

/* hdl/pe_array_top.sv */
// PE array top level
// Broadcast decoder, weight and activation stores, start decode and the PE grid

`timescale 1ns/1ps
`default_nettype none

`include "pe_array_consts.svh"

module pe_array_top
    import pe_data_pkg::*;
(
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic [`SEL_W-1:0]                            pe_row_select,
    input  logic [`SEL_W-1:0]                            pe_col_select,
    input  logic                                         global_start,
    input  logic                                         pe_start,
    input  act_t                                         pe_activation_threshold,
    input  logic                                         broadcast_enable,
    input  logic                                         broadcast_weights,
    input  logic                                         broadcast_activations,
    input  logic [`SEL_W-1:0]                            broadcast_row_select,
    input  logic [`SEL_W-1:0]                            broadcast_col_select,
    input  logic                                         broadcast_all,
    input  logic [`GRID_DIM*$bits(weight_tile_t)-1:0]    row_weight_buffer,
    input  logic [`GRID_DIM*$bits(act_tile_t)-1:0]      col_activation_buffer,
    output logic                                         pe_done,
    output result_tile_t                                 pe_result_tile,
    output logic                                         all_pes_done
);

    tile_load_if ld ();

    weight_tile_t [`GRID_DIM-1:0][`GRID_DIM-1:0]    weight_tiles;
    act_tile_t [`GRID_DIM-1:0][`GRID_DIM-1:0]       act_tiles;
    result_tile_t [`GRID_DIM-1:0][`GRID_DIM-1:0]    result_grid;
    logic [`GRID_DIM-1:0][`GRID_DIM-1:0]            start_grid;
    logic [`GRID_DIM-1:0][`GRID_DIM-1:0]            done_grid;

    // ====================
    // Tile loading
    // ====================

    broadcast_decoder u_decoder (
        .broadcast_enable      (broadcast_enable),
        .broadcast_weights     (broadcast_weights),
        .broadcast_activations (broadcast_activations),
        .broadcast_all         (broadcast_all),
        .broadcast_row_select  (broadcast_row_select),
        .broadcast_col_select  (broadcast_col_select),
        .row_weight_buffer     (row_weight_buffer),
        .col_activation_buffer (col_activation_buffer),
        .ld                    (ld)
    );

    tile_store #(.tile_t(weight_tile_t), .by_row(1'b1)) weight_store (
        .clk   (clk),
        .rst_n (rst_n),
        .ld    (ld),
        .tiles (weight_tiles)
    );

    tile_store #(.tile_t(act_tile_t), .by_row(1'b0)) act_store (
        .clk   (clk),
        .rst_n (rst_n),
        .ld    (ld),
        .tiles (act_tiles)
    );

    // ====================
    // Start decode
    // ====================

    always_comb begin
        start_grid = '0;
        if (global_start) begin
            start_grid = '1;
        end else begin
            start_grid[pe_row_select][pe_col_select] = pe_start;
        end
    end

    // PE grid, each PE fed from its own store slot
    for (genvar r = 0; r < `GRID_DIM; r++) begin : g_row
        for (genvar c = 0; c < `GRID_DIM; c++) begin : g_col
            processing_element u_pe (
                .clk       (clk),
                .rst_n     (rst_n),
                .start     (start_grid[r][c]),
                .threshold (pe_activation_threshold),
                .weights   (weight_tiles[r][c]),
                .acts      (act_tiles[r][c]),
                .done      (done_grid[r][c]),
                .result    (result_grid[r][c])
            );
        end
    end

    // Selected PE and the array-wide done flag
    assign pe_done        = done_grid[pe_row_select][pe_col_select];
    assign pe_result_tile = result_grid[pe_row_select][pe_col_select];
    assign all_pes_done   = &done_grid;

endmodule

`default_nettype wire

/* testbench/pe_array_checker.sv */
// Checker for the PE array
// Store model, reference tile product and per-cycle comparison of the DUT outputs

`timescale 1ns/1ps
`default_nettype none

`include "pe_array_consts.svh"

module pe_array_checker
    import pe_data_pkg::*;
(
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic [`SEL_W-1:0]                            pe_row_select,
    input  logic [`SEL_W-1:0]                            pe_col_select,
    input  logic                                         global_start,
    input  logic                                         pe_start,
    input  act_t                                         pe_activation_threshold,
    input  logic                                         broadcast_enable,
    input  logic                                         broadcast_weights,
    input  logic                                         broadcast_activations,
    input  logic [`SEL_W-1:0]                            broadcast_row_select,
    input  logic [`SEL_W-1:0]                            broadcast_col_select,
    input  logic                                         broadcast_all,
    input  logic [`GRID_DIM*$bits(weight_tile_t)-1:0]    row_weight_buffer,
    input  logic [`GRID_DIM*$bits(act_tile_t)-1:0]      col_activation_buffer,
    input  logic                                         pe_done,
    input  result_tile_t                                 pe_result_tile,
    input  logic                                         all_pes_done,
    output int                                           error_count,
    output int                                           result_count
);

    localparam int weight_bits = $bits(weight_tile_t);
    localparam int act_bits    = $bits(act_tile_t);

    weight_tile_t    weight_model [`GRID_DIM][`GRID_DIM];
    act_tile_t       act_model [`GRID_DIM][`GRID_DIM];
    result_tile_t    expected [`GRID_DIM][`GRID_DIM];
    // Next accumulation edge of a busy PE, 0 when not busy
    int              plane_edge [`GRID_DIM][`GRID_DIM];
    logic            done_model [`GRID_DIM][`GRID_DIM];
    // PE not started since reset, result still zero
    logic            fresh [`GRID_DIM][`GRID_DIM];

    // Sum over planes p and inner k of thresholded a[i][k] * 2**p where w[p][k][j] is set
    function automatic result_tile_t reference_tile(input weight_tile_t w, input act_tile_t a,
                                                    input act_t thr);
        result_tile_t res;
        int           sum;
        int           act_val;
        for (int i = 0; i < `TILE_DIM; i++) begin
            for (int j = 0; j < `TILE_DIM; j++) begin
                sum = 0;
                for (int k = 0; k < `TILE_DIM; k++) begin
                    act_val = (a[i][k] >= thr) ? int'(a[i][k]) : 0;
                    for (int p = 0; p < `NUM_PLANES; p++) begin
                        if (w[p][k][j]) begin
                            sum = sum + act_val * (1 << p);
                        end
                    end
                end
                res[i][j] = sum;
            end
        end
        return res;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        int   sr;
        int   sc;
        logic all_done;
        if (!rst_n) begin
            for (int r = 0; r < `GRID_DIM; r++) begin
                for (int c = 0; c < `GRID_DIM; c++) begin
                    weight_model[r][c] = '0;
                    act_model[r][c]    = '0;
                    expected[r][c]     = '0;
                    plane_edge[r][c]   = 0;
                    done_model[r][c]   = 1'b0;
                    fresh[r][c]        = 1'b1;
                end
            end
        end else begin
            // ====================
            // Compare outputs before this edge
            // ====================
            sr       = int'(pe_row_select);
            sc       = int'(pe_col_select);
            all_done = 1'b1;
            for (int r = 0; r < `GRID_DIM; r++) begin
                for (int c = 0; c < `GRID_DIM; c++) begin
                    all_done = all_done & done_model[r][c];
                end
            end
            if (pe_done !== done_model[sr][sc]) begin
                error_count++;
                $display("Mismatch pe_done (PE %0d,%0d) at %0t: got %h, expected %h",
                         sr, sc, $time, pe_done, done_model[sr][sc]);
            end
            if (all_pes_done !== all_done) begin
                error_count++;
                $display("Mismatch all_pes_done at %0t: got %h, expected %h",
                         $time, all_pes_done, all_done);
            end
            if (done_model[sr][sc] || fresh[sr][sc]) begin
                result_count++;
                if (pe_result_tile !== expected[sr][sc]) begin
                    error_count++;
                    $display("Mismatch pe_result_tile (PE %0d,%0d) at %0t: got %h, expected %h",
                             sr, sc, $time, pe_result_tile, expected[sr][sc]);
                end
            end

            // ====================
            // Advance the model
            // ====================
            for (int r = 0; r < `GRID_DIM; r++) begin
                for (int c = 0; c < `GRID_DIM; c++) begin
                    if (plane_edge[r][c] == `NUM_PLANES) begin
                        plane_edge[r][c] = 0;
                        done_model[r][c] = 1'b1;
                        expected[r][c]   = reference_tile(weight_model[r][c], act_model[r][c],
                                                          pe_activation_threshold);
                    end else if (plane_edge[r][c] != 0) begin
                        plane_edge[r][c]++;
                    end else if (global_start || (pe_start && r == sr && c == sc)) begin
                        plane_edge[r][c] = 1;
                        done_model[r][c] = 1'b0;
                        fresh[r][c]      = 1'b0;
                    end
                end
            end
            // Loads land after the PE update, which still sees the old tiles
            if (broadcast_enable) begin
                for (int r = 0; r < `GRID_DIM; r++) begin
                    for (int c = 0; c < `GRID_DIM; c++) begin
                        if (broadcast_all || (broadcast_weights &&
                                              r == int'(broadcast_row_select))) begin
                            weight_model[r][c] = row_weight_buffer[r*weight_bits +: weight_bits];
                        end
                        if (broadcast_all || (broadcast_activations &&
                                              c == int'(broadcast_col_select))) begin
                            act_model[r][c] = col_activation_buffer[c*act_bits +: act_bits];
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_pe_array.sv */
// PE array testbench
// Clock, reset, broadcast and start stimulus, xorshift data and watchdog

`timescale 1ns/1ps
`default_nettype none

`include "pe_array_consts.svh"

module tb_pe_array
    import pe_data_pkg::*;
();

    localparam int          cycle_ns        = 20;
    localparam int          reset_cycles    = 10;
    // Started runs, each threshold step counted as one
    localparam int          num_tests       = 13;
    localparam int          watchdog_cycles = num_tests * 40;
    localparam logic [31:0] seed            = 32'd88685;
    localparam int          weight_buf_w    = `GRID_DIM * $bits(weight_tile_t);
    localparam int          act_buf_w       = `GRID_DIM * $bits(act_tile_t);

    logic                    clk;
    logic                    rst_n;
    logic [`SEL_W-1:0]       pe_row_select;
    logic [`SEL_W-1:0]       pe_col_select;
    logic                    global_start;
    logic                    pe_start;
    act_t                    pe_activation_threshold;
    logic                    broadcast_enable;
    logic                    broadcast_weights;
    logic                    broadcast_activations;
    logic [`SEL_W-1:0]       broadcast_row_select;
    logic [`SEL_W-1:0]       broadcast_col_select;
    logic                    broadcast_all;
    logic [weight_buf_w-1:0] row_weight_buffer;
    logic [act_buf_w-1:0]    col_activation_buffer;
    logic                    pe_done;
    result_tile_t            pe_result_tile;
    logic                    all_pes_done;

    logic [31:0]             rng_state;
    logic [weight_buf_w-1:0] next_wbuf;
    logic [act_buf_w-1:0]    next_abuf;
    int                      error_count;
    int                      result_count;

    pe_array_top DUT (.*);

    pe_array_checker u_checker (.*);

    initial clk = 1'b0;
    always #(cycle_ns / 2) clk = ~clk;

    // ====================
    // Stimulus helpers
    // ====================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic randomize_buffers();
        for (int n = 0; n < weight_buf_w / 32; n++) begin
            rng_state = xorshift32(rng_state);
            next_wbuf[n*32 +: 32] = rng_state;
        end
        for (int n = 0; n < act_buf_w / 32; n++) begin
            rng_state = xorshift32(rng_state);
            next_abuf[n*32 +: 32] = rng_state;
        end
    endtask

    // One-cycle load strobe with the prepared buffers
    task automatic broadcast(input logic en, input logic w, input logic a, input logic all,
                             input logic [`SEL_W-1:0] row, input logic [`SEL_W-1:0] col);
        @(posedge clk);
        row_weight_buffer     <= next_wbuf;
        col_activation_buffer <= next_abuf;
        broadcast_enable      <= en;
        broadcast_weights     <= w;
        broadcast_activations <= a;
        broadcast_all         <= all;
        broadcast_row_select  <= row;
        broadcast_col_select  <= col;
        @(posedge clk);
        broadcast_enable      <= 1'b0;
        broadcast_weights     <= 1'b0;
        broadcast_activations <= 1'b0;
        broadcast_all         <= 1'b0;
    endtask

    task automatic select_pe(input logic [`SEL_W-1:0] row, input logic [`SEL_W-1:0] col);
        @(posedge clk);
        pe_row_select <= row;
        pe_col_select <= col;
        @(posedge clk);
    endtask

    // Returns at the edge where the start is sampled
    task automatic start_pe(input logic [`SEL_W-1:0] row, input logic [`SEL_W-1:0] col);
        @(posedge clk);
        pe_row_select <= row;
        pe_col_select <= col;
        pe_start      <= 1'b1;
        @(posedge clk);
        pe_start      <= 1'b0;
    endtask

    task automatic wait_pe_done();
        do @(posedge clk); while (!pe_done);
    endtask

    task automatic run_all(input act_t thr);
        @(posedge clk);
        pe_activation_threshold <= thr;
        global_start            <= 1'b1;
        @(posedge clk);
        global_start            <= 1'b0;
        do @(posedge clk); while (!all_pes_done);
        for (int d = 0; d < `GRID_DIM; d++) begin
            select_pe(d[`SEL_W-1:0], d[`SEL_W-1:0]);
        end
    endtask

    // ====================
    // Test sequence
    // ====================

    initial begin
        rng_state = seed;
        next_wbuf = '0;
        next_abuf = '0;
        rst_n                   <= 1'b0;
        pe_row_select           <= '0;
        pe_col_select           <= '0;
        global_start            <= 1'b0;
        pe_start                <= 1'b0;
        pe_activation_threshold <= -8'sd128;
        broadcast_enable        <= 1'b0;
        broadcast_weights       <= 1'b0;
        broadcast_activations   <= 1'b0;
        broadcast_row_select    <= '0;
        broadcast_col_select    <= '0;
        broadcast_all           <= 1'b0;
        row_weight_buffer       <= '0;
        col_activation_buffer   <= '0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        // Reset values, seen by the checker on every edge
        select_pe(2'd0, 2'd0);
        select_pe(2'd3, 2'd3);

        // Line loads crossing at PE (2,1)
        randomize_buffers();
        broadcast(1'b1, 1'b1, 1'b0, 1'b0, 2'd2, 2'd0);
        randomize_buffers();
        broadcast(1'b1, 1'b0, 1'b1, 1'b0, 2'd0, 2'd1);
        start_pe(2'd2, 2'd1);
        wait_pe_done();

        // Loads outside a PE's row and column leave it alone
        randomize_buffers();
        broadcast(1'b1, 1'b1, 1'b0, 1'b0, 2'd0, 2'd0);
        start_pe(2'd3, 2'd1);
        wait_pe_done();
        randomize_buffers();
        broadcast(1'b1, 1'b0, 1'b1, 1'b0, 2'd0, 2'd3);
        start_pe(2'd0, 2'd1);
        wait_pe_done();
        select_pe(2'd2, 2'd1);

        // Load-all and global start, every PE read back
        randomize_buffers();
        broadcast(1'b1, 1'b0, 1'b0, 1'b1, 2'd0, 2'd0);
        run_all(-8'sd128);
        for (int r = 0; r < `GRID_DIM; r++) begin
            for (int c = 0; c < `GRID_DIM; c++) begin
                select_pe(r[`SEL_W-1:0], c[`SEL_W-1:0]);
            end
        end

        // Threshold sweep over the extremes and a few steps between
        run_all(8'sd127);
        run_all(-8'sd1);
        run_all(8'sd0);
        run_all(8'sd1);
        run_all(8'sd64);
        run_all(-8'sd64);
        rng_state = xorshift32(rng_state);
        run_all(act_t'(rng_state[7:0]));

        // Strobes without enable, then a start while busy
        randomize_buffers();
        broadcast(1'b0, 1'b1, 1'b1, 1'b1, 2'd2, 2'd1);
        start_pe(2'd2, 2'd1);
        wait_pe_done();
        start_pe(2'd1, 2'd2);
        @(posedge clk);
        pe_start <= 1'b1;
        @(posedge clk);
        pe_start <= 1'b0;
        wait_pe_done();

        repeat (2) @(posedge clk);
        if (result_count == 0) begin
            $display("No result tile was compared during the run");
        end
        $display("Result checks: %0d, errors: %0d", result_count, error_count);
        if (error_count == 0 && result_count > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+hdl
hdl/pe_data_pkg.sv
hdl/pe_ctrl_pkg.sv
hdl/tile_load_if.sv
hdl/broadcast_decoder.sv
hdl/tile_store.sv
hdl/processing_element.sv
hdl/pe_array_top.sv
testbench/pe_array_checker.sv
testbench/tb_pe_array.sv

/* Bender.yml */
package:
  name: pe_array

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pe_data_pkg.sv
      - hdl/pe_ctrl_pkg.sv
      - hdl/tile_load_if.sv
      - hdl/broadcast_decoder.sv
      - hdl/tile_store.sv
      - hdl/processing_element.sv
      - hdl/pe_array_top.sv
      - target: simulation
        files:
          - testbench/pe_array_checker.sv
          - testbench/tb_pe_array.sv
